// File: hw/bypass_drop.sv
`default_nettype none
`timescale 1ns/10ps

module bypass_drop import bypass_pkg::*; (
    input  logic  core_clk,
    input  logic  core_rstn,

    input  logic  in_valid,
    input  beat_t in_beat,
    output logic  in_ready,

    output logic  out_valid,
    output beat_t out_beat,
    input  logic  out_ready,

    output logic  drop_pulse
);

    logic sop;
    logic dropping;
    logic drop_code;
    logic drop_now;

    assign drop_code = (in_beat.tdest == TDEST_DROP);

    // decision comes from the first beat, then the flag holds it.
    assign drop_now = sop ? drop_code : dropping;

    assign out_beat  = in_beat;
    assign out_valid = in_valid && !drop_now;

    // dropped beats are sunk here, never stalled downstream.
    assign in_ready = drop_now ? 1'b1 : out_ready;

    assign drop_pulse = in_valid && sop && drop_code;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            sop      <= 1'b1;
            dropping <= 1'b0;
        end else if (in_valid && in_ready) begin
            sop <= in_beat.last;
            if (sop) begin
                dropping <= drop_code;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/bypass_lane.sv
`default_nettype none
`timescale 1ns/10ps

module bypass_lane import bypass_pkg::*; (
    input  logic  core_clk,
    input  logic  core_rstn,

    input  logic  in_valid,
    input  beat_t in_beat,
    output logic  in_ready,

    input  logic  swap_paths,

    output logic  straight_valid,
    output beat_t straight_beat,
    input  logic  straight_ready,

    output logic  crossed_valid,
    output beat_t crossed_beat,
    input  logic  crossed_ready,

    output logic  drop_pulse
);

    logic  drop_valid;
    beat_t drop_beat;
    logic  drop_ready;

    logic  fifo_valid;
    beat_t fifo_beat;
    logic  fifo_ready;

    logic  fifo_sop;
    logic  sel_q;
    logic  sel;

    bypass_drop u_drop (
        .core_clk   (core_clk),
        .core_rstn  (core_rstn),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .in_ready   (in_ready),
        .out_valid  (drop_valid),
        .out_beat   (drop_beat),
        .out_ready  (drop_ready),
        .drop_pulse (drop_pulse)
    );

    bypass_pkt_fifo u_fifo (
        .core_clk  (core_clk),
        .core_rstn (core_rstn),
        .in_valid  (drop_valid),
        .in_beat   (drop_beat),
        .in_ready  (drop_ready),
        .out_valid (fifo_valid),
        .out_beat  (fifo_beat),
        .out_ready (fifo_ready)
    );

    // first beat steers by the live mode, the rest by the latched one.
    assign sel = fifo_sop ? swap_paths : sel_q;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            fifo_sop <= 1'b1;
            sel_q    <= 1'b0;
        end else if (fifo_valid && fifo_ready) begin
            fifo_sop <= fifo_beat.last;
            if (fifo_sop) begin
                sel_q <= swap_paths;
            end
        end
    end

    assign straight_beat  = fifo_beat;
    assign crossed_beat   = fifo_beat;
    assign straight_valid = fifo_valid && !sel;
    assign crossed_valid  = fifo_valid && sel;
    assign fifo_ready     = sel ? crossed_ready : straight_ready;

endmodule

`default_nettype wire

// File: hw/bypass_out_mux.sv
`default_nettype none
`timescale 1ns/10ps

module bypass_out_mux import bypass_pkg::*; (
    input  logic  core_clk,
    input  logic  core_rstn,

    input  logic  a_valid,
    input  beat_t a_beat,
    output logic  a_ready,

    input  logic  b_valid,
    input  beat_t b_beat,
    output logic  b_ready,

    output logic  out_valid,
    output beat_t out_beat,
    input  logic  out_ready
);

    mux_state_t state;
    // 1 when b had the last grant.
    logic       last_b;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            state  <= idle;
            last_b <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (a_valid && (!b_valid || last_b)) begin
                        state  <= grant0;
                        last_b <= 1'b0;
                    end else if (b_valid) begin
                        state  <= grant1;
                        last_b <= 1'b1;
                    end
                end
                grant0: begin
                    if (a_valid && out_ready && a_beat.last) begin
                        state <= idle;
                    end
                end
                grant1: begin
                    if (b_valid && out_ready && b_beat.last) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_comb begin
        out_valid = 1'b0;
        out_beat  = a_beat;
        a_ready   = 1'b0;
        b_ready   = 1'b0;
        case (state)
            grant0: begin
                out_valid = a_valid;
                a_ready   = out_ready;
            end
            grant1: begin
                out_valid = b_valid;
                out_beat  = b_beat;
                b_ready   = out_ready;
            end
            default: begin
                out_valid = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/bypass_pkg.sv
`default_nettype none

package bypass_pkg;

    // two mac ports, the swap wiring assumes exactly two.
    localparam int NUM_PORTS = 2;

    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [63:0] word_t;
    typedef logic [7:0]  keep_t;
    typedef logic [0:0]  port_t;
    typedef logic [1:0]  tdest_t;

    // ingress switch code for packets to delete.
    localparam tdest_t TDEST_DROP = 2'd3;

    typedef struct packed {
        word_t  data;
        keep_t  keep;
        logic   last;
        port_t  tid;
        tdest_t tdest;
    } beat_t;

    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    // one extra bit so a full buffer is representable.
    typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;

    typedef logic [31:0] cnt_t;

    typedef logic [1:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    localparam reg_addr_t REG_CONFIG = 2'd0;
    localparam reg_addr_t REG_DROPS0 = 2'd1;
    localparam reg_addr_t REG_DROPS1 = 2'd2;

    typedef enum logic [1:0] {
        idle,
        grant0,
        grant1
    } mux_state_t;

    typedef enum logic {
        wait_req,
        ack_high
    } reg_state_t;

endpackage

`default_nettype wire

// File: hw/bypass_pkt_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module bypass_pkt_fifo import bypass_pkg::*; (
    input  logic  core_clk,
    input  logic  core_rstn,

    input  logic  in_valid,
    input  beat_t in_beat,
    output logic  in_ready,

    output logic  out_valid,
    output beat_t out_beat,
    input  logic  out_ready
);

    beat_t mem [FIFO_DEPTH];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t beat_cnt;
    fifo_cnt_t pkt_cnt;

    logic wr_en;
    logic rd_en;
    logic pkt_in;
    logic pkt_out;

    assign in_ready = (beat_cnt != fifo_cnt_t'(FIFO_DEPTH));

    // only whole packets are released.
    assign out_valid = (pkt_cnt != '0);
    assign out_beat  = mem[rd_ptr];

    assign wr_en   = in_valid && in_ready;
    assign rd_en   = out_valid && out_ready;
    assign pkt_in  = wr_en && in_beat.last;
    assign pkt_out = rd_en && out_beat.last;

    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // beat occupancy, drives in_ready.
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            beat_cnt <= '0;
        end else begin
            beat_cnt <= beat_cnt + fifo_cnt_t'(wr_en) - fifo_cnt_t'(rd_en);
        end
    end

    // complete packets held.
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            pkt_cnt <= '0;
        end else begin
            pkt_cnt <= pkt_cnt + fifo_cnt_t'(pkt_in) - fifo_cnt_t'(pkt_out);
        end
    end

endmodule

`default_nettype wire

// File: hw/bypass_regs.sv
`default_nettype none
`timescale 1ns/10ps

module bypass_regs import bypass_pkg::*; (
    input  logic      core_clk,
    input  logic      core_rstn,

    input  logic      reg_req,
    input  logic      reg_we,
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    output logic      reg_ack,
    output reg_data_t reg_rdata,

    input  logic      drop_pulse0,
    input  logic      drop_pulse1,

    output logic      swap_paths
);

    reg_state_t           state;
    logic                 access;
    logic [NUM_PORTS-1:0] pulse;
    logic [NUM_PORTS-1:0] clr;
    cnt_t                 drop_cnt [NUM_PORTS];

    // one access per request, taken on entry to the handshake.
    assign access  = (state == wait_req) && reg_req;
    assign reg_ack = (state == ack_high);

    assign pulse = {drop_pulse1, drop_pulse0};
    assign clr[0] = access && reg_we && (reg_addr == REG_DROPS0);
    assign clr[1] = access && reg_we && (reg_addr == REG_DROPS1);

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            state <= wait_req;
        end else if (access) begin
            state <= ack_high;
        end else if (state == ack_high && !reg_req) begin
            state <= wait_req;
        end
    end

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            swap_paths <= 1'b0;
        end else if (access && reg_we && reg_addr == REG_CONFIG) begin
            swap_paths <= reg_wdata[0];
        end
    end

    // saturating, clear wins over a pulse in the same cycle.
    always_ff @(posedge core_clk) begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (!core_rstn || clr[i]) begin
                drop_cnt[i] <= '0;
            end else if (pulse[i] && drop_cnt[i] != '1) begin
                drop_cnt[i] <= drop_cnt[i] + 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (access) begin
            case (reg_addr)
                REG_CONFIG: reg_rdata <= {31'b0, swap_paths};
                REG_DROPS0: reg_rdata <= drop_cnt[0];
                REG_DROPS1: reg_rdata <= drop_cnt[1];
                default:    reg_rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/smartnic_bypass.sv
`default_nettype none
`timescale 1ns/10ps

module smartnic_bypass import bypass_pkg::*; (
    input  logic      core_clk,
    input  logic      core_rstn,

    input  logic      in_valid  [NUM_PORTS],
    input  beat_t     in_beat   [NUM_PORTS],
    output logic      in_ready  [NUM_PORTS],

    output logic      out_valid [NUM_PORTS],
    output beat_t     out_beat  [NUM_PORTS],
    input  logic      out_ready [NUM_PORTS],

    input  logic      reg_req,
    input  logic      reg_we,
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    output logic      reg_ack,
    output reg_data_t reg_rdata
);

    logic  straight_valid [NUM_PORTS];
    beat_t straight_beat  [NUM_PORTS];
    logic  straight_ready [NUM_PORTS];
    logic  crossed_valid  [NUM_PORTS];
    beat_t crossed_beat   [NUM_PORTS];
    logic  crossed_ready  [NUM_PORTS];
    logic  drop_pulse     [NUM_PORTS];
    logic  swap_paths;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        bypass_lane u_lane (
            .core_clk       (core_clk),
            .core_rstn      (core_rstn),
            .in_valid       (in_valid[i]),
            .in_beat        (in_beat[i]),
            .in_ready       (in_ready[i]),
            .swap_paths     (swap_paths),
            .straight_valid (straight_valid[i]),
            .straight_beat  (straight_beat[i]),
            .straight_ready (straight_ready[i]),
            .crossed_valid  (crossed_valid[i]),
            .crossed_beat   (crossed_beat[i]),
            .crossed_ready  (crossed_ready[i]),
            .drop_pulse     (drop_pulse[i])
        );

        // own lane straight, the other lane crossed.
        bypass_out_mux u_mux (
            .core_clk  (core_clk),
            .core_rstn (core_rstn),
            .a_valid   (straight_valid[i]),
            .a_beat    (straight_beat[i]),
            .a_ready   (straight_ready[i]),
            .b_valid   (crossed_valid[1-i]),
            .b_beat    (crossed_beat[1-i]),
            .b_ready   (crossed_ready[1-i]),
            .out_valid (out_valid[i]),
            .out_beat  (out_beat[i]),
            .out_ready (out_ready[i])
        );
    end

    bypass_regs u_regs (
        .core_clk    (core_clk),
        .core_rstn   (core_rstn),
        .reg_req     (reg_req),
        .reg_we      (reg_we),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_ack     (reg_ack),
        .reg_rdata   (reg_rdata),
        .drop_pulse0 (drop_pulse[0]),
        .drop_pulse1 (drop_pulse[1]),
        .swap_paths  (swap_paths)
    );

endmodule

`default_nettype wire

// File: sim/tb_smartnic_bypass.sv
`default_nettype none
`timescale 1ns/10ps

module tb_smartnic_bypass import bypass_pkg::*; ();

    localparam int PKTS    = 40;
    localparam int MAX_LEN = 16;
    localparam int PHASES  = 5;
    localparam int PLANNED_BEATS   = PHASES * NUM_PORTS * PKTS * MAX_LEN;
    localparam int WATCHDOG_CYCLES = PLANNED_BEATS * 4 + 2000;
    // longest wait for the FIFOs to empty once the senders are done.
    localparam int DRAIN_CYCLES    = 16 * FIFO_DEPTH;

    logic      core_clk;
    logic      core_rstn;
    logic      in_valid  [NUM_PORTS];
    beat_t     in_beat   [NUM_PORTS];
    logic      in_ready  [NUM_PORTS];
    logic      out_valid [NUM_PORTS];
    beat_t     out_beat  [NUM_PORTS];
    logic      out_ready [NUM_PORTS];
    logic      reg_req;
    logic      reg_we;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    logic      reg_ack;
    reg_data_t reg_rdata;

    integer seed;
    int     err_cnt;
    logic   swap_mode;
    logic   backpress;
    int     model_drops [NUM_PORTS];
    logic   mid_pkt     [NUM_PORTS];
    port_t  cur_src     [NUM_PORTS];

    // expected beats, named by output port then source port.
    beat_t exp_q00 [$];
    beat_t exp_q01 [$];
    beat_t exp_q10 [$];
    beat_t exp_q11 [$];

    smartnic_bypass DUT (
        .core_clk  (core_clk),
        .core_rstn (core_rstn),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready),
        .reg_req   (reg_req),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_ack   (reg_ack),
        .reg_rdata (reg_rdata)
    );

    initial begin
        core_clk = 1'b0;
        forever #50 core_clk = ~core_clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge core_clk);
        $display("watchdog expired after %0d cycles, traffic did not drain", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    // sink side ready pattern.
    always @(posedge core_clk) begin
        #1;
        for (int o = 0; o < NUM_PORTS; o++) begin
            out_ready[o] = backpress ? (($random(seed) & 1) != 0) : 1'b1;
        end
    end

    task automatic push_exp(input int o, input int s, input beat_t b);
        case (o * 2 + s)
            0: exp_q00.push_back(b);
            1: exp_q01.push_back(b);
            2: exp_q10.push_back(b);
            default: exp_q11.push_back(b);
        endcase
    endtask

    function automatic int pending_beats();
        return exp_q00.size() + exp_q01.size() + exp_q10.size() + exp_q11.size();
    endfunction

    task automatic check_beat(input int o, input beat_t got);
        beat_t exp;
        logic  empty;
        exp = '0;
        case ({o[0], got.tid})
            2'b00: empty = (exp_q00.size() == 0);
            2'b01: empty = (exp_q01.size() == 0);
            2'b10: empty = (exp_q10.size() == 0);
            default: empty = (exp_q11.size() == 0);
        endcase
        if (!empty) begin
            case ({o[0], got.tid})
                2'b00: exp = exp_q00.pop_front();
                2'b01: exp = exp_q01.pop_front();
                2'b10: exp = exp_q10.pop_front();
                default: exp = exp_q11.pop_front();
            endcase
        end
        if (empty) begin
            err_cnt++;
            $display("unexpected beat on output port %0d from source %0d", o, got.tid);
        end else if (got !== exp) begin
            err_cnt++;
            $display("Error: out_beat[%0d] got %h expected %h", o, got, exp);
        end
    endtask

    always @(negedge core_clk) begin
        if (core_rstn) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (out_valid[o] && out_ready[o]) begin
                    if (mid_pkt[o] && out_beat[o].tid != cur_src[o]) begin
                        err_cnt++;
                        $display("packets from both sources interleaved on output port %0d", o);
                    end
                    cur_src[o] = out_beat[o].tid;
                    mid_pkt[o] = !out_beat[o].last;
                    check_beat(o, out_beat[o]);
                end
            end
        end
    end

    task automatic send_packets(input int p, input int npkts);
        int    k;
        int    i;
        int    len;
        int    gap;
        int    dst;
        logic  drop;
        logic  acc;
        beat_t b;
        for (k = 0; k < npkts; k++) begin
            len  = 1 + ($unsigned($random(seed)) % MAX_LEN);
            drop = ($unsigned($random(seed)) % 5) == 0;
            dst  = swap_mode ? 1 - p : p;
            if (drop) begin
                model_drops[p]++;
            end
            for (i = 0; i < len; i++) begin
                b.data = word_t'({$random(seed), $random(seed)});
                b.keep = keep_t'($random(seed));
                b.last = (i == len - 1);
                b.tid  = port_t'(p);
                if (i == 0) begin
                    b.tdest = drop ? TDEST_DROP : tdest_t'($unsigned($random(seed)) % 3);
                end else begin
                    b.tdest = tdest_t'($random(seed));
                end
                if (!drop) begin
                    push_exp(dst, p, b);
                end
                in_valid[p] = 1'b1;
                in_beat[p]  = b;
                do begin
                    @(negedge core_clk);
                    acc = in_ready[p];
                    @(posedge core_clk);
                    #1;
                end while (!acc);
            end
            in_valid[p] = 1'b0;
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) begin
                @(posedge core_clk);
                #1;
            end
        end
    endtask

    task automatic run_traffic(input int npkts, input logic bp);
        int n;
        backpress = bp;
        fork
            send_packets(0, npkts);
            send_packets(1, npkts);
        join
        n = 0;
        while (pending_beats() != 0 && n < DRAIN_CYCLES) begin
            @(posedge core_clk);
            n++;
        end
        backpress = 1'b0;
        repeat (2) @(posedge core_clk);
        #1;
    endtask

    // full four-phase cycle, returns at 1 ns after an edge.
    task automatic reg_access(input logic we, input reg_addr_t addr, input reg_data_t wdata,
                              output reg_data_t rdata);
        int   n;
        logic got_ack;
        rdata = '0;
        if (reg_ack !== 1'b0) begin
            err_cnt++;
            $display("reg_ack was already high before a request to address %0d", addr);
        end
        reg_req   = 1'b1;
        reg_we    = we;
        reg_addr  = addr;
        reg_wdata = wdata;
        n         = 0;
        got_ack   = 1'b0;
        while (!got_ack && n < 20) begin
            @(negedge core_clk);
            got_ack = (reg_ack === 1'b1);
            if (!got_ack) begin
                @(posedge core_clk);
                #1;
                n++;
            end
        end
        if (!got_ack) begin
            err_cnt++;
            $display("register access to address %0d got no ack within 20 cycles", addr);
            reg_req = 1'b0;
        end else begin
            rdata = reg_rdata;
            @(posedge core_clk);
            #1;
            @(negedge core_clk);
            if (reg_ack !== 1'b1) begin
                err_cnt++;
                $display("reg_ack fell while reg_req was still high");
            end
            @(posedge core_clk);
            #1;
            reg_req = 1'b0;
            n = 0;
            while (reg_ack !== 1'b0 && n < 20) begin
                @(posedge core_clk);
                #1;
                n++;
            end
            if (reg_ack !== 1'b0) begin
                err_cnt++;
                $display("reg_ack stayed high after reg_req was dropped");
            end
        end
        @(posedge core_clk);
        #1;
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t wdata);
        reg_data_t unused;
        reg_access(1'b1, addr, wdata, unused);
    endtask

    task automatic read_expect(input reg_addr_t addr, input reg_data_t exp);
        reg_data_t rd;
        reg_access(1'b0, addr, '0, rd);
        if (rd !== exp) begin
            err_cnt++;
            $display("Error: reg_rdata at address %0d got %h expected %h", addr, rd, exp);
        end
    endtask

    task automatic check_and_clear_drops();
        read_expect(REG_DROPS0, reg_data_t'(model_drops[0]));
        read_expect(REG_DROPS1, reg_data_t'(model_drops[1]));
        reg_write(REG_DROPS0, '0);
        reg_write(REG_DROPS1, '0);
        read_expect(REG_DROPS0, '0);
        read_expect(REG_DROPS1, '0);
        model_drops[0] = 0;
        model_drops[1] = 0;
    endtask

    task automatic set_mode(input logic swap);
        reg_write(REG_CONFIG, reg_data_t'(swap));
        read_expect(REG_CONFIG, reg_data_t'(swap));
        swap_mode = swap;
    endtask

    initial begin
        seed      = 17;
        err_cnt   = 0;
        swap_mode = 1'b0;
        backpress = 1'b0;
        core_rstn = 1'b0;
        reg_req   = 1'b0;
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_valid[p]    = 1'b0;
            in_beat[p]     = '0;
            out_ready[p]   = 1'b1;
            model_drops[p] = 0;
            mid_pkt[p]     = 1'b0;
            cur_src[p]     = '0;
        end
        repeat (5) @(posedge core_clk);
        #1;
        core_rstn = 1'b1;

        @(negedge core_clk);
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (out_valid[o] !== 1'b0) begin
                err_cnt++;
                $display("Error: out_valid[%0d] is %h expected %h", o, out_valid[o], 1'b0);
            end
            if (in_ready[o] !== 1'b1) begin
                err_cnt++;
                $display("Error: in_ready[%0d] is %h expected %h", o, in_ready[o], 1'b1);
            end
        end
        if (reg_ack !== 1'b0) begin
            err_cnt++;
            $display("reg_ack is not low after reset");
        end
        @(posedge core_clk);
        #1;
        read_expect(REG_CONFIG, '0);
        read_expect(REG_DROPS0, '0);
        read_expect(REG_DROPS1, '0);

        run_traffic(PKTS, 1'b0);
        check_and_clear_drops();

        // swap, then back to pass-through.
        set_mode(1'b1);
        run_traffic(PKTS, 1'b0);
        set_mode(1'b0);
        run_traffic(PKTS, 1'b0);

        // back-pressure in both modes.
        run_traffic(PKTS, 1'b1);
        set_mode(1'b1);
        run_traffic(PKTS, 1'b1);
        set_mode(1'b0);
        check_and_clear_drops();

        if (pending_beats() != 0) begin
            err_cnt++;
            $display("%0d expected beats never left the DUT", pending_beats());
        end
        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: smartnic_bypass.f
hw/bypass_pkg.sv
hw/bypass_drop.sv
hw/bypass_pkt_fifo.sv
hw/bypass_lane.sv
hw/bypass_out_mux.sv
hw/bypass_regs.sv
hw/smartnic_bypass.sv
sim/tb_smartnic_bypass.sv
